/* bpu_top.f */
hdl/bpu_pkg.sv
hdl/bpu_bank_table.sv
hdl/bpu_btb.sv
hdl/bpu_local_hist.sv
hdl/bpu_pht.sv
hdl/bpu_ras.sv
hdl/bpu_pc_gen.sv
hdl/bpu_top.sv
tests/tb_bpu_checks.sv
tests/tb_bpu.sv

/* run_sim.sh */
#!/bin/sh
# build and run the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_bpu -f bpu_top.f -o Vtb_bpu

./obj_dir/Vtb_bpu | tee sim.log

# fails the script unless the pass line is in the log
grep -q "All tests passed" sim.log
echo "simulation passed"

/* tests/tb_bpu.sv */
`timescale 1ns/1ps

module tb_bpu;

    localparam logic [31:0] INIT_PC      = 32'h1c00_0000;
    localparam int          RAS_DEPTH    = 4;
    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 16;
    // six tests in order, then slack
    localparam int          RUN_CYCLES   = RESET_CYCLES + 40 + 25 + 20 + 75 + 30 + 20 + 100;
    localparam logic [19:0] OUTCOMES     = 20'b1111_1111_1000_1111_1111;  // bit i, step i

    logic                   clk;
    logic                   rst_n;
    logic                   flush;
    logic [31:0]            redir_pc;
    bpu_pkg::correct_info_t corr;
    logic                   valid;
    logic                   ready;
    bpu_pkg::fetch_pkt_t    pkt;

    int     chk_err;
    int     misc_err    = 0;
    int     errs_before = 0;
    int     tests_run   = 0;
    int     tests_bad   = 0;
    integer seed        = 32'h92f8;

    bpu_top #(.INIT_PC(INIT_PC), .RAS_DEPTH(RAS_DEPTH)) i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .redir_pc (redir_pc),
        .corr     (corr),
        .valid    (valid),
        .ready    (ready),
        .pkt      (pkt)
    );

    tb_bpu_checks #(.INIT_PC(INIT_PC), .RAS_DEPTH(RAS_DEPTH)) i_checks (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .redir_pc (redir_pc),
        .ready    (ready),
        .corr     (corr),
        .valid    (valid),
        .pkt      (pkt),
        .err_cnt  (chk_err)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic bpu_pkg::correct_info_t build_corr(input logic [31:0] pc,
        input bpu_pkg::br_type_t kind, input logic taken, input logic [31:0] target,
        input logic type_miss, input logic target_miss);
        bpu_pkg::correct_info_t c;
        c             = '0;
        c.update      = 1'b1;
        c.pc          = pc;
        c.is_branch   = 1'b1;
        c.br_type     = kind;
        c.taken       = taken;
        c.target_pc   = target;
        c.type_miss   = type_miss;
        c.target_miss = target_miss;
        return c;
    endfunction

    // one cycle on the correction port
    task automatic send_corr(input bpu_pkg::correct_info_t c);
        @(negedge clk);
        corr = c;
        @(negedge clk);
        corr = '0;
    endtask

    task automatic redirect(input logic [31:0] target);
        @(negedge clk);
        flush    = 1'b1;
        redir_pc = target;
        @(negedge clk);
        flush = 1'b0;
    endtask

    // hold the packet at addr a cycle, take it, then hold the successor
    task automatic fetch_at(input logic [31:0] addr);
        @(negedge clk);
        ready = 1'b0;
        redirect(addr);
        ready = 1'b1;
        @(negedge clk);
        ready = 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_valid(input int limit);
        int n;
        n = 0;
        while (!valid && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!valid) begin
            misc_err++;
            $display("valid never rose within %0d cycles of reset", limit);
        end
    endtask

    task automatic end_test(input string name);
        int now;
        now = chk_err + misc_err;
        tests_run++;
        if (now != errs_before) begin
            tests_bad++;
        end
        $display("test %0d %s: %s, %0d errors", tests_run, name,
                 (now == errs_before) ? "ok" : "FAILED", now - errs_before);
        errs_before = now;
    endtask

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("watchdog: run still going after %0d cycles", RUN_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        bpu_pkg::correct_info_t c;
        bpu_pkg::pred_info_t    obs;
        int                     rnd;
        rst_n    = 1'b0;
        flush    = 1'b0;
        redir_pc = '0;
        corr     = '0;
        ready    = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        wait_valid(20);
        @(negedge clk);
        ready = 1'b1;                        // straight-line stepping
        repeat (8) @(negedge clk);
        repeat (24) begin
            rnd   = $random(seed);
            ready = rnd[0];
            @(negedge clk);
        end
        end_test("reset and sequencing");

        @(negedge clk);
        ready    = 1'b1;
        flush    = 1'b1;                     // flush together with ready
        redir_pc = 32'h1c00_0a44;
        @(negedge clk);
        flush = 1'b0;
        repeat (4) @(negedge clk);
        fetch_at(32'h1c00_0b04);             // enters at slot 1
        fetch_at(32'h1c00_0b10);
        end_test("flush");

        send_corr(build_corr(32'h1c00_2000, bpu_pkg::BR_JUMP, 1'b1, 32'h1c00_4000, 1'b1, 1'b1));
        fetch_at(32'h1c00_2000);
        fetch_at(32'h1c0c_2000);             // same index, other tag
        end_test("unconditional branch");

        send_corr(build_corr(32'h1c00_8000, bpu_pkg::BR_NORMAL, 1'b1, 32'h1c00_8040,
                             1'b1, 1'b0));
        redirect(32'h1c00_8000);
        for (int i = 0; i < 20; i++) begin
            obs       = pkt.info[0];         // counter and history as fetched
            c         = build_corr(32'h1c00_8000, bpu_pkg::BR_NORMAL, OUTCOMES[i],
                                   32'h1c00_8040, 1'b0, 1'b0);
            c.scnt    = obs.scnt;
            c.history = obs.history;
            send_corr(c);
        end
        fetch_at(32'h1c00_8000);
        end_test("conditional counters");

        send_corr(build_corr(32'h1c00_3000, bpu_pkg::BR_CALL, 1'b1, 32'h1c00_9000, 1'b0, 1'b0));
        send_corr(build_corr(32'h1c00_3100, bpu_pkg::BR_CALL, 1'b1, 32'h1c00_9000, 1'b0, 1'b0));
        send_corr(build_corr(32'h1c00_3200, bpu_pkg::BR_CALL, 1'b1, 32'h1c00_9000, 1'b0, 1'b0));
        // learning the ret also pops the newest call
        send_corr(build_corr(32'h1c00_5004, bpu_pkg::BR_RET, 1'b1, 32'h0, 1'b1, 1'b0));
        fetch_at(32'h1c00_5004);
        send_corr(build_corr(32'h1c00_5004, bpu_pkg::BR_RET, 1'b1, 32'h0, 1'b0, 1'b0));
        fetch_at(32'h1c00_5004);
        end_test("call and return");

        send_corr(build_corr(32'h1c00_6000, bpu_pkg::BR_JUMP, 1'b1, 32'h1c00_7000, 1'b1, 1'b1));
        send_corr(build_corr(32'h1c00_6004, bpu_pkg::BR_JUMP, 1'b1, 32'h1c00_7800, 1'b1, 1'b1));
        fetch_at(32'h1c00_6000);             // slot 0 wins
        fetch_at(32'h1c00_6004);
        end_test("slot interplay");

        $display("tests run %0d, tests with errors %0d, total errors %0d",
                 tests_run, tests_bad, chk_err + misc_err);
        if (tests_bad == 0 && chk_err + misc_err == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* tests/tb_bpu_checks.sv */
`timescale 1ns/1ps

module tb_bpu_checks #(
    parameter logic [31:0] INIT_PC   = 32'h1c00_0000,
    parameter int          RAS_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic [31:0]             redir_pc,
    input  logic                    ready,
    input  bpu_pkg::correct_info_t  corr,
    input  logic                    valid,
    input  bpu_pkg::fetch_pkt_t     pkt,
    output int                      err_cnt
);

    localparam int TBL_DEPTH = 1 << bpu_pkg::BTB_IDX_W;
    localparam int CNT_DEPTH = 1 << bpu_pkg::PHT_IDX_W;

    // reference copies, filled only from the corrections seen on the port
    bpu_pkg::btb_entry_t btb_m  [2][TBL_DEPTH];
    bpu_pkg::hist_t      hist_m [2][TBL_DEPTH];
    logic [1:0]          pht_m  [2][CNT_DEPTH];
    logic [31:0]         ras_m  [RAS_DEPTH];
    int                  ras_n;                  // live stack entries
    logic [31:0]         m_pc;
    logic                m_valid;
    int                  errors = 0;

    bpu_pkg::btb_entry_t ent [2];
    bpu_pkg::hist_t      hst [2];
    logic [1:0]          cnt [2];
    logic [1:0]          hit;
    logic [1:0]          tk;
    logic [31:0]         tgt [2];
    logic [31:0]         ras_top_m;
    logic [31:0]         exp_npc;
    bpu_pkg::fetch_pkt_t exp_pkt;

    assign err_cnt = errors;

    // xor of pc[17:9] and pc[11:3]
    function automatic logic [8:0] tbl_idx(input logic [31:0] a);
        return a[17:9] ^ a[11:3];
    endfunction

    function automatic logic [1:0] sat_step(input logic [1:0] c, input logic up);
        if (up) begin
            return (c == 2'd3) ? 2'd3 : c + 2'd1;
        end
        return (c == 2'd0) ? 2'd0 : c - 2'd1;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] exp_v,
                                   input logic [127:0] act_v);
        errors++;
        $display("ERROR %s expected %h actual %h at %0t", name, exp_v, act_v, $time);
    endtask

    assign ras_top_m = (ras_n == 0) ? 32'd0 : ras_m[ras_n-1];  // empty stack reads zero

    always_comb begin
        exp_pkt    = '0;
        exp_pkt.pc = m_pc;
        for (int i = 0; i < 2; i++) begin
            ent[i] = btb_m[i][tbl_idx(m_pc)];
            hst[i] = hist_m[i][tbl_idx(m_pc)];
            cnt[i] = pht_m[i][{hst[i], m_pc[10:3]}];   // history above pc bits
            hit[i] = ent[i].is_branch && (ent[i].tag == m_pc[19:12]);
            tk[i]  = hit[i] && ((ent[i].br_type != bpu_pkg::BR_NORMAL) || cnt[i][1]);
            tgt[i] = (ent[i].br_type == bpu_pkg::BR_RET) ? ras_top_m : ent[i].target_pc;
            exp_pkt.info[i] = '{ent[i].is_branch, ent[i].br_type, tk[i], tgt[i],
                                cnt[i], hst[i], !hit[i]};
        end
        exp_pkt.mask[0] = !m_pc[2];
        exp_pkt.mask[1] = !(!m_pc[2] && tk[0]);
        if (!m_pc[2] && tk[0]) begin
            exp_npc = tgt[0];
        end else if (tk[1]) begin
            exp_npc = tgt[1];
        end else begin
            exp_npc = (m_pc & ~32'h7) + 32'd8;        // next aligned packet
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m_pc    <= INIT_PC;
            m_valid <= 1'b0;
            ras_n   <= 0;
            for (int i = 0; i < TBL_DEPTH; i++) begin
                btb_m[0][i]  <= '0;
                btb_m[1][i]  <= '0;
                hist_m[0][i] <= '0;
                hist_m[1][i] <= '0;
            end
            for (int i = 0; i < CNT_DEPTH; i++) begin
                pht_m[0][i] <= 2'd0;
                pht_m[1][i] <= 2'd0;
            end
        end else begin
            m_valid <= 1'b1;
            if (flush) begin
                m_pc <= redir_pc;
            end else if (m_valid && ready) begin
                m_pc <= exp_npc;
            end
            if (corr.update) begin
                if (corr.type_miss || corr.target_miss) begin
                    btb_m[corr.pc[2]][tbl_idx(corr.pc)] <=
                        '{corr.is_branch, corr.br_type, corr.pc[19:12], corr.target_pc};
                end
                hist_m[corr.pc[2]][tbl_idx(corr.pc)] <= corr.type_miss ?
                    {4'b0000, corr.taken} : {corr.history[3:0], corr.taken};
                pht_m[corr.pc[2]][{corr.history, corr.pc[10:3]}] <=
                    sat_step(corr.scnt, corr.taken);
                if (corr.br_type == bpu_pkg::BR_CALL) begin
                    if (ras_n < RAS_DEPTH) begin
                        ras_m[ras_n] <= corr.pc + 32'd4;
                        ras_n        <= ras_n + 1;
                    end else begin
                        for (int i = 0; i < RAS_DEPTH - 1; i++) begin
                            ras_m[i] <= ras_m[i+1];      // oldest falls off
                        end
                        ras_m[RAS_DEPTH-1] <= corr.pc + 32'd4;
                    end
                end else if (corr.br_type == bpu_pkg::BR_RET && ras_n > 0) begin
                    ras_n <= ras_n - 1;
                end
            end
        end
    end

    a_valid: assert property (@(posedge clk) disable iff (!rst_n) valid == m_valid)
        else report_mismatch("valid", 128'(m_valid), 128'(valid));

    a_pc: assert property (@(posedge clk) disable iff (!rst_n) pkt.pc == exp_pkt.pc)
        else report_mismatch("pkt.pc", 128'(exp_pkt.pc), 128'(pkt.pc));

    a_mask: assert property (@(posedge clk) disable iff (!rst_n) pkt.mask == exp_pkt.mask)
        else report_mismatch("pkt.mask", 128'(exp_pkt.mask), 128'(pkt.mask));

    // slot info covers taken, target, counter and history
    a_info0: assert property (@(posedge clk) disable iff (!rst_n)
        pkt.info[0] == exp_pkt.info[0])
        else report_mismatch("pkt.info[0]", 128'(exp_pkt.info[0]), 128'(pkt.info[0]));

    a_info1: assert property (@(posedge clk) disable iff (!rst_n)
        pkt.info[1] == exp_pkt.info[1])
        else report_mismatch("pkt.info[1]", 128'(exp_pkt.info[1]), 128'(pkt.info[1]));

endmodule

/* hdl/bpu_top.sv */
`timescale 1ns/1ps

module bpu_top #(
    parameter logic [31:0] INIT_PC   = 32'h1c00_0000,
    parameter int          RAS_DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,
    input  logic [31:0]                redir_pc,
    input  bpu_pkg::correct_info_t     corr,
    output logic                       valid,
    input  logic                       ready,
    output bpu_pkg::fetch_pkt_t        pkt
);

    logic [31:0]               pc;       // current fetch pc
    logic [1:0]                hit;
    bpu_pkg::btb_entry_t [1:0] entries;
    bpu_pkg::hist_t [1:0]      hist;
    logic [1:0][1:0]           scnt;
    logic [31:0]               ras_top;

    bpu_btb i_btb (
        .clk     (clk),
        .rst_n   (rst_n),
        .pc      (pc),
        .hit     (hit),
        .entries (entries),
        .corr    (corr)
    );

    bpu_local_hist i_hist (
        .clk   (clk),
        .rst_n (rst_n),
        .pc    (pc),
        .hist  (hist),
        .corr  (corr)
    );

    // indexed by the histories just read
    bpu_pht i_pht (
        .clk   (clk),
        .rst_n (rst_n),
        .pc    (pc),
        .hist  (hist),
        .scnt  (scnt),
        .corr  (corr)
    );

    bpu_ras #(.RAS_DEPTH(RAS_DEPTH)) i_ras (
        .clk   (clk),
        .rst_n (rst_n),
        .corr  (corr),
        .top   (ras_top)
    );

    bpu_pc_gen #(.INIT_PC(INIT_PC)) i_pc_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .redir_pc (redir_pc),
        .ready    (ready),
        .valid    (valid),
        .pc       (pc),
        .hit      (hit),
        .entries  (entries),
        .scnt     (scnt),
        .hist     (hist),
        .ras_top  (ras_top),
        .pkt      (pkt)
    );

endmodule

/* hdl/bpu_pc_gen.sv */
`timescale 1ns/1ps

module bpu_pc_gen #(
    parameter logic [31:0] INIT_PC = 32'h1c00_0000
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,
    input  logic [31:0]                redir_pc,
    input  logic                       ready,
    output logic                       valid,
    output logic [31:0]                pc,
    input  logic [1:0]                 hit,
    input  bpu_pkg::btb_entry_t [1:0]  entries,
    input  logic [1:0][1:0]            scnt,
    input  bpu_pkg::hist_t [1:0]       hist,
    input  logic [31:0]                ras_top,
    output bpu_pkg::fetch_pkt_t        pkt
);

    logic [1:0]       taken;
    logic [1:0][31:0] target;
    logic [1:0]       mask;
    logic [31:0]      seq_pc;  // next aligned packet
    logic [31:0]      npc;

    for (genvar i = 0; i < 2; i++) begin : g_slot
        // unconditional kinds always go, conditional ones follow the counter msb
        assign taken[i]  = hit[i] & ((entries[i].br_type != bpu_pkg::BR_NORMAL) | scnt[i][1]);
        assign target[i] = (entries[i].br_type == bpu_pkg::BR_RET) ? ras_top
                                                                   : entries[i].target_pc;

        assign pkt.info[i].is_branch   = entries[i].is_branch;
        assign pkt.info[i].br_type     = entries[i].br_type;
        assign pkt.info[i].taken       = taken[i];
        assign pkt.info[i].target_pc   = target[i];
        assign pkt.info[i].scnt        = scnt[i];
        assign pkt.info[i].history     = hist[i];
        assign pkt.info[i].need_update = ~hit[i];
    end

    assign seq_pc  = {pc[31:3] + 29'd1, 3'b000};
    assign mask[0] = ~pc[2];                // entering at slot 1 skips slot 0
    assign mask[1] = ~(mask[0] & taken[0]); // killed by a taken slot 0

    always_comb begin
        if (mask[0] && taken[0]) begin
            npc = target[0];
        end else if (taken[1]) begin
            npc = target[1];
        end else begin
            npc = seq_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc    <= INIT_PC;
            valid <= 1'b0;
        end else begin
            valid <= 1'b1;                  // one packet every cycle
            if (flush) begin
                pc <= redir_pc;             // wins over ready
            end else if (valid && ready) begin
                pc <= npc;
            end
        end
    end

    assign pkt.pc   = pc;
    assign pkt.mask = mask;

    // redirects come from the backend
    a_pc_align: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

/* hdl/bpu_ras.sv */
`timescale 1ns/1ps

module bpu_ras #(
    parameter int RAS_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  bpu_pkg::correct_info_t   corr,
    output logic [31:0]              top
);

    localparam int PTR_W = $clog2(RAS_DEPTH);

    logic [31:0]      stack [RAS_DEPTH];
    logic [PTR_W-1:0] top_ptr;  // newest entry
    logic [PTR_W-1:0] w_ptr;    // one above top
    logic             push;
    logic             pop;

    assign push = corr.update & (corr.br_type == bpu_pkg::BR_CALL);
    assign pop  = corr.update & (corr.br_type == bpu_pkg::BR_RET);
    assign top  = stack[top_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < RAS_DEPTH; i++) begin
                stack[i] <= '0;
            end
            top_ptr <= PTR_W'(RAS_DEPTH - 1);  // empty
            w_ptr   <= '0;
        end else if (push) begin
            stack[w_ptr] <= corr.pc + 32'd4;    // return lands after the call
            top_ptr      <= w_ptr;
            w_ptr        <= w_ptr + 1'b1;       // wraps, overwrites oldest
        end else if (pop) begin
            w_ptr   <= top_ptr;
            top_ptr <= top_ptr - 1'b1;
        end
    end

endmodule

/* hdl/bpu_pht.sv */
`timescale 1ns/1ps

module bpu_pht (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [31:0]              pc,
    input  bpu_pkg::hist_t [1:0]     hist,
    output logic [1:0][1:0]          scnt,
    input  bpu_pkg::correct_info_t   corr
);

    localparam int PHT_DEPTH = 1 << bpu_pkg::PHT_IDX_W;

    logic [1:0]                    cnt [2][PHT_DEPTH];  // one array per slot
    logic [bpu_pkg::PHT_IDX_W-1:0] widx;
    logic [1:0]                    next_cnt;

    // each slot has its own history, so two read indices
    for (genvar i = 0; i < 2; i++) begin : g_rd
        assign scnt[i] = cnt[i][bpu_pkg::pht_index(hist[i], pc)];
    end

    assign widx = bpu_pkg::pht_index(corr.history, corr.pc);  // index as seen at fetch

    // 2-bit saturating step from the returned count
    always_comb begin
        if (corr.taken) begin
            next_cnt = (corr.scnt == 2'b11) ? 2'b11 : corr.scnt + 2'd1;
        end else begin
            next_cnt = (corr.scnt == 2'b00) ? 2'b00 : corr.scnt - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < PHT_DEPTH; i++) begin
                cnt[0][i] <= 2'b00;  // strongly not-taken
                cnt[1][i] <= 2'b00;
            end
        end else if (corr.update) begin
            cnt[corr.pc[2]][widx] <= next_cnt;
        end
    end

endmodule

/* hdl/bpu_local_hist.sv */
`timescale 1ns/1ps

module bpu_local_hist (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [31:0]              pc,
    output bpu_pkg::hist_t [1:0]     hist,
    input  bpu_pkg::correct_info_t   corr
);

    logic [bpu_pkg::BTB_IDX_W-1:0] ridx;
    logic [bpu_pkg::BTB_IDX_W-1:0] widx;
    bpu_pkg::hist_t                new_hist;

    assign ridx = bpu_pkg::btb_index(pc);       // same hash as the btb
    assign widx = bpu_pkg::btb_index(corr.pc);

    // a kind miss means the old history was for something else
    assign new_hist = corr.type_miss ?
                      {{(bpu_pkg::HIST_W-1){1'b0}}, corr.taken} :
                      {corr.history[bpu_pkg::HIST_W-2:0], corr.taken};  // newest at bit 0

    bpu_bank_table #(
        .entry_t (bpu_pkg::hist_t),
        .DEPTH   (bpu_pkg::BTB_DEPTH)
    ) i_table (
        .clk   (clk),
        .rst_n (rst_n),
        .raddr (ridx),
        .rdata (hist),
        .we    (corr.update),  // every resolved branch
        .wbank (corr.pc[2]),
        .waddr (widx),
        .wdata (new_hist)
    );

endmodule

/* hdl/bpu_btb.sv */
`timescale 1ns/1ps

module bpu_btb (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [31:0]                pc,
    output logic [1:0]                 hit,
    output bpu_pkg::btb_entry_t [1:0]  entries,
    input  bpu_pkg::correct_info_t     corr
);

    logic                          we;
    logic [bpu_pkg::BTB_IDX_W-1:0] ridx;
    logic [bpu_pkg::BTB_IDX_W-1:0] widx;
    logic [bpu_pkg::TAG_W-1:0]     rtag;
    bpu_pkg::btb_entry_t           wentry;

    // only learn on a miss of kind or target
    assign we   = corr.update & (corr.type_miss | corr.target_miss);
    assign ridx = bpu_pkg::btb_index(pc);
    assign widx = bpu_pkg::btb_index(corr.pc);
    assign rtag = bpu_pkg::btb_tag(pc);

    assign wentry.is_branch = corr.is_branch;  // clears a stale entry on a false branch
    assign wentry.br_type   = corr.br_type;
    assign wentry.tag       = bpu_pkg::btb_tag(corr.pc);
    assign wentry.target_pc = corr.target_pc;

    bpu_bank_table #(
        .entry_t (bpu_pkg::btb_entry_t),
        .DEPTH   (bpu_pkg::BTB_DEPTH)
    ) i_table (
        .clk   (clk),
        .rst_n (rst_n),
        .raddr (ridx),
        .rdata (entries),
        .we    (we),
        .wbank (corr.pc[2]),
        .waddr (widx),
        .wdata (wentry)
    );

    // both slots share the packet tag
    for (genvar i = 0; i < 2; i++) begin : g_hit
        assign hit[i] = entries[i].is_branch & (entries[i].tag == rtag);
    end

endmodule

/* hdl/bpu_bank_table.sv */
`timescale 1ns/1ps

module bpu_bank_table #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 512
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [$clog2(DEPTH)-1:0] raddr,   // same index for both banks
    output entry_t [1:0]             rdata,
    input  logic                     we,
    input  logic                     wbank,   // pc[2] of the writer
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  entry_t                   wdata
);

    entry_t bank [2][DEPTH];

    // async read, one entry per slot
    assign rdata[0] = bank[0][raddr];
    assign rdata[1] = bank[1][raddr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                bank[0][i] <= '0;
                bank[1][i] <= '0;
            end
        end else if (we) begin
            bank[wbank][waddr] <= wdata;  // seen by lookups next cycle
        end
    end

    // writer index must fall inside the table when DEPTH is not a power of two
    a_waddr_range: assert property (@(posedge clk) disable iff (!rst_n)
        we |-> (int'(waddr) < DEPTH));

endmodule

/* hdl/bpu_pkg.sv */
package bpu_pkg;

    localparam int BTB_IDX_W = 9;                 // index into each bank
    localparam int BTB_DEPTH = 1 << BTB_IDX_W;    // entries per bank, btb and local history
    localparam int TAG_W     = 8;                 // taken from pc[19:12]
    localparam int HIST_W    = 5;                 // local history length
    localparam int PHT_PC_W  = 8;                 // pc[10:3] in the pattern index
    localparam int PHT_IDX_W = HIST_W + PHT_PC_W;

    typedef enum logic [1:0] {
        BR_NORMAL,  // conditional
        BR_JUMP,
        BR_CALL,
        BR_RET
    } br_type_t;

    typedef logic [HIST_W-1:0] hist_t;

    typedef struct packed {
        logic                 is_branch;
        br_type_t             br_type;
        logic [TAG_W-1:0]     tag;
        logic [31:0]          target_pc;
    } btb_entry_t;

    // per-slot prediction, comes back with the correction
    typedef struct packed {
        logic                 is_branch;
        br_type_t             br_type;
        logic                 taken;
        logic [31:0]          target_pc;
        logic [1:0]           scnt;
        hist_t                history;
        logic                 need_update;  // no btb hit
    } pred_info_t;

    typedef struct packed {
        logic [31:0]          pc;
        logic [1:0]           mask;         // bit i set when slot i is live
        pred_info_t [1:0]     info;
    } fetch_pkt_t;

    typedef struct packed {
        logic                 update;
        logic [31:0]          pc;
        logic                 is_branch;
        br_type_t             br_type;
        logic                 taken;
        logic [31:0]          target_pc;
        logic                 type_miss;
        logic                 target_miss;
        logic [1:0]           scnt;         // counter seen at fetch
        hist_t                history;      // history seen at fetch
    } correct_info_t;

    // fold two overlapping pc windows
    function automatic logic [BTB_IDX_W-1:0] btb_index(input logic [31:0] pc);
        return pc[BTB_IDX_W+8:9] ^ pc[BTB_IDX_W+2:3];
    endfunction

    function automatic logic [TAG_W-1:0] btb_tag(input logic [31:0] pc);
        return pc[TAG_W+11:12];
    endfunction

    function automatic logic [PHT_IDX_W-1:0] pht_index(input hist_t h, input logic [31:0] pc);
        return {h, pc[PHT_PC_W+2:3]};  // history on top
    endfunction

endpackage
